//--- flist.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
result_unit.sv
mips_lite_core.sv
tb_mips_lite.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; a failing run ends with a non-zero status.
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_mips_lite \
    -f flist.f \
    -o tb_mips_lite

./obj_dir/tb_mips_lite

//--- tb_mips_model.svh
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

localparam int          SETUP_LEN = 8;
localparam int          PROG_LEN  = 200;
localparam int          HALT_IDX  = SETUP_LEN + PROG_LEN;
localparam logic [31:0] HALT_PC   = 32'(HALT_IDX * 4);

localparam isa_pkg::funct_e ALU_FNS [8] = '{isa_pkg::F_ADDU, isa_pkg::F_SUBU,
    isa_pkg::F_AND, isa_pkg::F_OR, isa_pkg::F_XOR, isa_pkg::F_NOR,
    isa_pkg::F_SLT, isa_pkg::F_SLTU};
localparam isa_pkg::funct_e SHIFT_FNS [3] = '{isa_pkg::F_SLL, isa_pkg::F_SRL, isa_pkg::F_SRA};
localparam isa_pkg::opcode_e IMM_OPS [7] = '{isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI,
    isa_pkg::OP_SLTIU, isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI};
localparam isa_pkg::opcode_e LOAD_OPS [5] = '{isa_pkg::OP_LB, isa_pkg::OP_LBU,
    isa_pkg::OP_LH, isa_pkg::OP_LHU, isa_pkg::OP_LW};
localparam isa_pkg::opcode_e STORE_OPS [3] = '{isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW};

logic [31:0] rng;
logic [31:0] m_regs [32];
logic [31:0] m_dmem [64];
logic [31:0] m_pc;
logic [31:0] m_npc;
int          n_exec;
int          n_writes;

function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

function automatic int pick(input int n);
    return int'(xorshift() % 32'(n));
endfunction

function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = xorshift();
    return r[15:0];
endfunction

function automatic logic [31:0] enc_r(input isa_pkg::funct_e fn, input int rs, input int rt,
                                      input int rd, input int sa);
    return {isa_pkg::OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
endfunction

function automatic logic [31:0] enc_i(input isa_pkg::opcode_e op, input int rs, input int rt,
                                      input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

function automatic logic [31:0] enc_j(input isa_pkg::opcode_e op, input int idx);
    return {op, 26'(idx)}; // word index, upper pc bits are zero here
endfunction

function automatic void build_program();
    int               kind;
    int               rs;
    int               rt;
    int               rd;
    int               off;
    int               tgt;
    logic             prev_ctl;
    isa_pkg::opcode_e op;
    prev_ctl = 1'b0;
    foreach (imem[i]) imem[i] = 32'h0;
    for (int r = 1; r < SETUP_LEN; r++) begin
        imem[r - 1] = enc_i(isa_pkg::OP_ADDIU, 0, r, rand16());
    end
    imem[SETUP_LEN - 1] = enc_i(isa_pkg::OP_ADDIU, 0, 8, 16'h0080); // base at window middle
    for (int i = SETUP_LEN; i < HALT_IDX; i++) begin
        kind = pick(10);
        if (prev_ctl || i == HALT_IDX - 1) kind = pick(8); // delay slot stays plain
        rs = pick(8);
        rt = pick(8);
        rd = pick(8); // r0 now and then
        off = pick(256) - 128;
        tgt = i + 2 + pick(6);
        if (tgt > HALT_IDX) tgt = HALT_IDX;
        case (kind)
            0, 1: imem[i] = enc_r(ALU_FNS[pick(8)], rs, rt, rd, 0);
            2:    imem[i] = enc_r(SHIFT_FNS[pick(3)], 0, rt, rd, pick(32));
            3, 4: imem[i] = enc_i(IMM_OPS[pick(7)], rs, rd, rand16());
            5, 6: begin
                op = LOAD_OPS[pick(5)];
                if (op == isa_pkg::OP_LW) off = off & ~3;
                else if (op == isa_pkg::OP_LH || op == isa_pkg::OP_LHU) off = off & ~1;
                imem[i] = enc_i(op, 8, rd, 16'(off));
            end
            7: begin
                op = STORE_OPS[pick(3)];
                if (op == isa_pkg::OP_SW) off = off & ~3;
                else if (op == isa_pkg::OP_SH) off = off & ~1;
                imem[i] = enc_i(op, 8, rt, 16'(off));
            end
            8: imem[i] = enc_i(pick(2) == 0 ? isa_pkg::OP_BEQ : isa_pkg::OP_BNE,
                               rs, rt, 16'(tgt - i - 1));
            default: imem[i] = enc_j(pick(2) == 0 ? isa_pkg::OP_J : isa_pkg::OP_JAL, tgt);
        endcase
        prev_ctl = (kind >= 8);
    end
    imem[HALT_IDX] = enc_j(isa_pkg::OP_J, HALT_IDX); // spins with a nop slot
endfunction

function automatic void fill_data_window();
    foreach (dmem[i]) begin
        dmem[i] = xorshift();
        m_dmem[i] = dmem[i];
    end
endfunction

// one instruction at m_pc, returns 1 when a register is written
function automatic logic model_step(output logic [31:0] wpc, output logic [4:0] wnum,
                                    output logic [31:0] wval);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] tgt;
    logic [4:0]  sa;
    int          idx;
    int          sh;
    logic        taken;
    ins = imem[m_pc[9:2]];
    a = m_regs[ins[25:21]];
    b = m_regs[ins[20:16]];
    sa = ins[10:6];
    sext = {{16{ins[15]}}, ins[15:0]};
    zext = {16'h0, ins[15:0]};
    addr = a + sext;
    idx = int'(addr[7:2]);
    sh = 8 * int'(addr[1:0]);
    word = m_dmem[idx] >> sh; // addressed byte at the bottom
    wpc = m_pc;
    wnum = ins[20:16];
    wval = 32'h0;
    taken = 1'b0;
    tgt = m_pc + 32'd4 + {sext[29:0], 2'b00};
    case (isa_pkg::opcode_e'(ins[31:26]))
        isa_pkg::OP_SPECIAL: begin
            wnum = ins[15:11];
            case (isa_pkg::funct_e'(ins[5:0]))
                isa_pkg::F_ADDU: wval = a + b;
                isa_pkg::F_SUBU: wval = a - b;
                isa_pkg::F_AND:  wval = a & b;
                isa_pkg::F_OR:   wval = a | b;
                isa_pkg::F_XOR:  wval = a ^ b;
                isa_pkg::F_NOR:  wval = ~(a | b);
                isa_pkg::F_SLT:  wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                isa_pkg::F_SLTU: wval = (a < b) ? 32'd1 : 32'd0;
                isa_pkg::F_SLL:  wval = b << sa;
                isa_pkg::F_SRL:  wval = b >> sa;
                isa_pkg::F_SRA:  wval = $signed(b) >>> sa;
                default:         wnum = 5'd0;
            endcase
        end
        isa_pkg::OP_ADDIU: wval = a + sext;
        isa_pkg::OP_SLTI:  wval = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
        isa_pkg::OP_SLTIU: wval = (a < sext) ? 32'd1 : 32'd0;
        isa_pkg::OP_ANDI:  wval = a & zext;
        isa_pkg::OP_ORI:   wval = a | zext;
        isa_pkg::OP_XORI:  wval = a ^ zext;
        isa_pkg::OP_LUI:   wval = {ins[15:0], 16'h0};
        isa_pkg::OP_LB:    wval = {{24{word[7]}}, word[7:0]};
        isa_pkg::OP_LBU:   wval = {24'h0, word[7:0]};
        isa_pkg::OP_LH:    wval = {{16{word[15]}}, word[15:0]};
        isa_pkg::OP_LHU:   wval = {16'h0, word[15:0]};
        isa_pkg::OP_LW:    wval = m_dmem[idx];
        isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW: begin
            wnum = 5'd0;
            if (ins[31:26] == isa_pkg::OP_SB) m_dmem[idx][sh +: 8] = b[7:0];
            else if (ins[31:26] == isa_pkg::OP_SH) m_dmem[idx][sh +: 16] = b[15:0];
            else m_dmem[idx] = b;
        end
        isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
            wnum = 5'd0;
            taken = (a == b) == (ins[31:26] == isa_pkg::OP_BEQ);
        end
        isa_pkg::OP_J, isa_pkg::OP_JAL: begin
            taken = 1'b1;
            tgt = {m_pc[31:28], ins[25:0], 2'b00};
            wnum = (ins[31:26] == isa_pkg::OP_JAL) ? `CPU_LINK_REG : 5'd0;
            wval = m_pc + 32'd8; // link skips the delay slot
        end
        default: wnum = 5'd0;
    endcase
    if (wnum != 5'd0) m_regs[wnum] = wval;
    m_pc = m_npc;
    m_npc = taken ? tgt : m_npc + 32'd4;
    return wnum != 5'd0;
endfunction

function automatic void run_model();
    logic [31:0] wpc;
    logic [31:0] wval;
    logic [4:0]  wnum;
    foreach (m_regs[i]) m_regs[i] = 32'h0;
    m_pc = `CPU_RESET_PC;
    m_npc = m_pc + 32'd4;
    n_exec = 0;
    n_writes = 0;
    while (m_pc != HALT_PC) begin
        if (model_step(wpc, wnum, wval)) begin
            exp_pc.push_back(wpc);
            exp_num.push_back(wnum);
            exp_val.push_back(wval);
            n_writes++;
        end
        n_exec++;
    end
endfunction

`endif

//--- tb_mips_lite.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_mips_lite;

    logic                   clk;
    logic                   resetn;
    logic                   inst_sram_en;
    logic [`CPU_XLEN-1:0]   inst_sram_addr;
    logic [`CPU_XLEN-1:0]   inst_sram_rdata = '0;
    logic                   data_sram_en;
    logic [3:0]             data_sram_wen;
    logic [`CPU_XLEN-1:0]   data_sram_addr;
    logic [`CPU_XLEN-1:0]   data_sram_wdata;
    logic [`CPU_XLEN-1:0]   data_sram_rdata = '0;
    logic [`CPU_XLEN-1:0]   debug_wb_pc;
    logic [3:0]             debug_wb_rf_wen;
    logic [`CPU_REG_AW-1:0] debug_wb_rf_wnum;
    logic [`CPU_XLEN-1:0]   debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [64]; // data window at byte addresses 0x00 to 0xff
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_val [$];
    int          n_traced;
    bit          model_ready;

    `include "tb_mips_model.svh"

    mips_lite_core uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // both memories answer one cycle after the enable
    always @(posedge clk) begin
        logic [31:0] merged;
        if (inst_sram_en) inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        if (data_sram_en) begin
            data_sram_rdata <= dmem[data_sram_addr[7:2]];
            merged = dmem[data_sram_addr[7:2]];
            for (int b = 0; b < 4; b++) begin
                if (data_sram_wen[b]) merged[8*b +: 8] = data_sram_wdata[8*b +: 8];
            end
            if (data_sram_wen != 4'b0000) dmem[data_sram_addr[7:2]] <= merged;
        end
    end

    // trace against the model in program order
    always @(negedge clk) begin
        if (resetn && debug_wb_rf_wen != 4'b0000) begin
            if (exp_pc.size() == 0) begin
                $display("register write to r%0d from pc %h after the last expected write",
                         debug_wb_rf_wnum, debug_wb_pc);
                $display("sim failed");
                $fatal(1, "unexpected register write");
            end else begin
                check($sformatf("write %0d wen", n_traced), 32'hf, 32'(debug_wb_rf_wen));
                check($sformatf("write %0d pc", n_traced), exp_pc.pop_front(), debug_wb_pc);
                check($sformatf("write %0d wnum", n_traced), 32'(exp_num.pop_front()),
                      32'(debug_wb_rf_wnum));
                check($sformatf("write %0d wdata", n_traced), exp_val.pop_front(),
                      debug_wb_rf_wdata);
                n_traced++;
            end
        end
    end

    initial begin
        wait (model_ready);
        repeat (20 * n_exec + 100) @(posedge clk);
        $display("timeout, the core did not reach the halt loop in time");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        resetn = 1'b0;
        n_traced = 0;
        rng = 32'd36;
        build_program();
        fill_data_window();
        run_model();
        model_ready = 1'b1;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        // the halt jump retiring means everything older is done
        while (debug_wb_pc !== HALT_PC) @(negedge clk);
        repeat (10) @(negedge clk); // stray writes would show up here
        check("write count", 32'(n_writes), 32'(n_traced));
        foreach (dmem[i]) begin
            check($sformatf("data word %0d", i), m_dmem[i], dmem[i]);
        end
        $display("sim passed");
        $finish;
    end

endmodule

//--- mips_lite_core.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mips_lite_core (
    input  logic                   clk,
    input  logic                   resetn,
    output logic                   inst_sram_en,
    output logic [`CPU_XLEN-1:0]   inst_sram_addr,
    input  logic [`CPU_XLEN-1:0]   inst_sram_rdata,
    output logic                   data_sram_en,
    output logic [3:0]             data_sram_wen,
    output logic [`CPU_XLEN-1:0]   data_sram_addr,
    output logic [`CPU_XLEN-1:0]   data_sram_wdata,
    input  logic [`CPU_XLEN-1:0]   data_sram_rdata,
    output logic [`CPU_XLEN-1:0]   debug_wb_pc,
    output logic [3:0]             debug_wb_rf_wen,
    output logic [`CPU_REG_AW-1:0] debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0]   debug_wb_rf_wdata
);

    // fetch and branch
    logic                   stall;
    logic                   branch_taken;
    logic [`CPU_XLEN-1:0]   branch_target;
    logic [`CPU_XLEN-1:0]   fetch_pc;

    logic [`CPU_REG_AW-1:0] rs_addr;
    logic [`CPU_REG_AW-1:0] rt_addr;
    logic [`CPU_XLEN-1:0]   rs_data;
    logic [`CPU_XLEN-1:0]   rt_data;

    // decode to execute
    logic                   id_valid;
    logic [`CPU_XLEN-1:0]   id_pc;
    isa_pkg::alu_op_e       id_alu_op;
    logic [`CPU_XLEN-1:0]   id_src_a;
    logic [`CPU_XLEN-1:0]   id_src_b;
    logic [`CPU_XLEN-1:0]   id_store_data;
    pipe_pkg::mem_size_e    id_mem_size;
    logic                   id_load_signed;
    logic                   id_store;
    pipe_pkg::wb_src_e      id_wb_src;
    logic [`CPU_REG_AW-1:0] id_dest;
    logic                   id_we;

    // execute to memory, plus forwarding
    logic [`CPU_REG_AW-1:0] ex_dest;
    logic                   ex_we;
    logic                   ex_is_load;
    logic [`CPU_XLEN-1:0]   ex_value;
    logic                   mem_valid;
    logic [`CPU_XLEN-1:0]   mem_pc;
    logic [`CPU_REG_AW-1:0] mem_dest;
    logic                   mem_we;
    pipe_pkg::wb_src_e      mem_wb_src;
    pipe_pkg::mem_size_e    mem_size;
    logic                   mem_load_signed;
    logic [1:0]             mem_offset;
    logic [`CPU_XLEN-1:0]   mem_alu;
    logic [`CPU_XLEN-1:0]   mem_value;
    logic [`CPU_REG_AW-1:0] wb_dest;
    logic                   wb_we;
    logic [`CPU_XLEN-1:0]   wb_value;

    fetch_unit u_fetch (.*);

    decode_unit u_decode (.*);

    reg_file u_rf (
        .clk     (clk),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      (wb_we),
        .wa      (wb_dest),
        .wd      (wb_value)
    );

    execute_unit u_execute (.*);

    result_unit u_result (.*);

endmodule

//--- result_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module result_unit (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`CPU_XLEN-1:0]   data_sram_rdata,
    input  logic                   mem_valid,
    input  logic [`CPU_XLEN-1:0]   mem_pc,
    input  logic [`CPU_REG_AW-1:0] mem_dest,
    input  logic                   mem_we,
    input  pipe_pkg::wb_src_e      mem_wb_src,
    input  pipe_pkg::mem_size_e    mem_size,
    input  logic                   mem_load_signed,
    input  logic [1:0]             mem_offset,
    input  logic [`CPU_XLEN-1:0]   mem_alu,
    output logic [`CPU_XLEN-1:0]   mem_value,
    output logic [`CPU_REG_AW-1:0] wb_dest,
    output logic                   wb_we,
    output logic [`CPU_XLEN-1:0]   wb_value,
    output logic [`CPU_XLEN-1:0]   debug_wb_pc,
    output logic [3:0]             debug_wb_rf_wen,
    output logic [`CPU_REG_AW-1:0] debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0]   debug_wb_rf_wdata
);

    logic [`CPU_XLEN-1:0] lane_data;
    logic [`CPU_XLEN-1:0] load_val;
    logic                 wb_valid;
    logic                 wb_we_q;

    assign lane_data = data_sram_rdata >> {mem_offset, 3'b000}; // addressed lane to bit 0

    always_comb begin
        case (mem_size)
            pipe_pkg::MEM_BYTE:
                load_val = {{24{mem_load_signed & lane_data[7]}}, lane_data[7:0]};
            pipe_pkg::MEM_HALF:
                load_val = {{16{mem_load_signed & lane_data[15]}}, lane_data[15:0]};
            default:
                load_val = data_sram_rdata;
        endcase
    end

    assign mem_value = (mem_wb_src == pipe_pkg::WB_MEM) ? load_val : mem_alu;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
            wb_we_q <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
            wb_we_q <= mem_we;
        end
        debug_wb_pc <= mem_pc;
        wb_dest     <= mem_dest;
        wb_value    <= mem_value;
    end

    assign wb_we             = wb_valid && wb_we_q;
    assign debug_wb_rf_wen   = {4{wb_we}};
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_value;

endmodule

//--- execute_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_unit (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   id_valid,
    input  logic [`CPU_XLEN-1:0]   id_pc,
    input  isa_pkg::alu_op_e       id_alu_op,
    input  logic [`CPU_XLEN-1:0]   id_src_a,
    input  logic [`CPU_XLEN-1:0]   id_src_b,
    input  logic [`CPU_XLEN-1:0]   id_store_data,
    input  pipe_pkg::mem_size_e    id_mem_size,
    input  logic                   id_load_signed,
    input  logic                   id_store,
    input  pipe_pkg::wb_src_e      id_wb_src,
    input  logic [`CPU_REG_AW-1:0] id_dest,
    input  logic                   id_we,
    output logic [`CPU_REG_AW-1:0] ex_dest,
    output logic                   ex_we,
    output logic                   ex_is_load,
    output logic [`CPU_XLEN-1:0]   ex_value,
    output logic                   data_sram_en,
    output logic [3:0]             data_sram_wen,
    output logic [`CPU_XLEN-1:0]   data_sram_addr,
    output logic [`CPU_XLEN-1:0]   data_sram_wdata,
    output logic                   mem_valid,
    output logic [`CPU_XLEN-1:0]   mem_pc,
    output logic [`CPU_REG_AW-1:0] mem_dest,
    output logic                   mem_we,
    output pipe_pkg::wb_src_e      mem_wb_src,
    output pipe_pkg::mem_size_e    mem_size,
    output logic                   mem_load_signed,
    output logic [1:0]             mem_offset,
    output logic [`CPU_XLEN-1:0]   mem_alu
);

    logic [`CPU_XLEN-1:0] alu;
    logic [3:0]           lane_mask;

    always_comb begin
        case (id_alu_op)
            isa_pkg::ALU_ADD:  alu = id_src_a + id_src_b;
            isa_pkg::ALU_SUB:  alu = id_src_a - id_src_b;
            isa_pkg::ALU_AND:  alu = id_src_a & id_src_b;
            isa_pkg::ALU_OR:   alu = id_src_a | id_src_b;
            isa_pkg::ALU_XOR:  alu = id_src_a ^ id_src_b;
            isa_pkg::ALU_NOR:  alu = ~(id_src_a | id_src_b);
            isa_pkg::ALU_SLT:  alu = {31'h0, $signed(id_src_a) < $signed(id_src_b)};
            isa_pkg::ALU_SLTU: alu = {31'h0, id_src_a < id_src_b};
            isa_pkg::ALU_SLL:  alu = id_src_a << id_src_b[4:0];
            isa_pkg::ALU_SRL:  alu = id_src_a >> id_src_b[4:0];
            isa_pkg::ALU_SRA:  alu = $signed(id_src_a) >>> id_src_b[4:0];
            isa_pkg::ALU_LUI:  alu = {id_src_b[15:0], 16'h0};
            default:           alu = id_src_a + id_src_b;
        endcase
    end

    assign ex_dest    = id_dest;
    assign ex_we      = id_valid && id_we;
    assign ex_is_load = id_valid && id_wb_src == pipe_pkg::WB_MEM;
    assign ex_value   = (id_wb_src == pipe_pkg::WB_LINK) ? id_pc + 32'd8 : alu;

    // store data copied onto every lane
    always_comb begin
        case (id_mem_size)
            pipe_pkg::MEM_BYTE: begin
                lane_mask = 4'b0001 << alu[1:0];
                data_sram_wdata = {4{id_store_data[7:0]}};
            end
            pipe_pkg::MEM_HALF: begin
                lane_mask = alu[1] ? 4'b1100 : 4'b0011;
                data_sram_wdata = {2{id_store_data[15:0]}};
            end
            default: begin
                lane_mask = 4'b1111;
                data_sram_wdata = id_store_data;
            end
        endcase
    end

    assign data_sram_en   = id_valid && id_mem_size != pipe_pkg::MEM_NONE;
    assign data_sram_wen  = (id_valid && id_store) ? lane_mask : 4'b0000;
    assign data_sram_addr = {alu[31:2], 2'b00};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
            mem_we <= 1'b0;
        end else begin
            mem_valid <= id_valid;
            mem_we <= ex_we;
        end
        mem_pc          <= id_pc;
        mem_dest        <= id_dest;
        mem_wb_src      <= id_wb_src;
        mem_size        <= id_mem_size;
        mem_load_signed <= id_load_signed;
        mem_offset      <= alu[1:0];
        mem_alu         <= ex_value; // link value already folded in
    end

endmodule

//--- decode_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decode_unit (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [`CPU_XLEN-1:0]     inst_sram_rdata,
    input  logic [`CPU_XLEN-1:0]     fetch_pc,
    output logic [`CPU_REG_AW-1:0]   rs_addr,
    output logic [`CPU_REG_AW-1:0]   rt_addr,
    input  logic [`CPU_XLEN-1:0]     rs_data,
    input  logic [`CPU_XLEN-1:0]     rt_data,
    input  logic [`CPU_REG_AW-1:0]   ex_dest,
    input  logic                     ex_we,
    input  logic                     ex_is_load,
    input  logic [`CPU_XLEN-1:0]     ex_value,
    input  logic [`CPU_REG_AW-1:0]   mem_dest,
    input  logic                     mem_we,
    input  logic [`CPU_XLEN-1:0]     mem_value,
    input  logic [`CPU_REG_AW-1:0]   wb_dest,
    input  logic                     wb_we,
    input  logic [`CPU_XLEN-1:0]     wb_value,
    output logic                     stall,
    output logic                     branch_taken,
    output logic [`CPU_XLEN-1:0]     branch_target,
    output logic                     id_valid,
    output logic [`CPU_XLEN-1:0]     id_pc,
    output isa_pkg::alu_op_e         id_alu_op,
    output logic [`CPU_XLEN-1:0]     id_src_a,
    output logic [`CPU_XLEN-1:0]     id_src_b,
    output logic [`CPU_XLEN-1:0]     id_store_data,
    output pipe_pkg::mem_size_e      id_mem_size,
    output logic                     id_load_signed,
    output logic                     id_store,
    output pipe_pkg::wb_src_e        id_wb_src,
    output logic [`CPU_REG_AW-1:0]   id_dest,
    output logic                     id_we
);

    logic                   dec_ok;
    logic [5:0]             op;
    logic [5:0]             fn;
    logic [4:0]             sa;
    logic [15:0]            imm;
    logic [`CPU_XLEN-1:0]   imm_s;
    logic [`CPU_XLEN-1:0]   imm_z;
    logic [`CPU_XLEN-1:0]   pc4;
    logic [`CPU_XLEN-1:0]   rs_val;
    logic [`CPU_XLEN-1:0]   rt_val;
    logic [`CPU_XLEN-1:0]   src_a;
    logic [`CPU_XLEN-1:0]   src_b;
    isa_pkg::alu_op_e       alu_op;
    pipe_pkg::mem_size_e    mem_size;
    pipe_pkg::wb_src_e      wb_src;
    logic [`CPU_REG_AW-1:0] dest;
    logic                   we;
    logic                   load_signed;
    logic                   store;
    logic                   uses_rs;
    logic                   uses_rt;
    logic                   is_shift;
    logic                   is_branch;
    logic                   is_jump;
    logic                   br_ne;
    logic                   taken;

    assign op      = inst_sram_rdata[31:26];
    assign rs_addr = inst_sram_rdata[25:21];
    assign rt_addr = inst_sram_rdata[20:16];
    assign sa      = inst_sram_rdata[10:6];
    assign fn      = inst_sram_rdata[5:0];
    assign imm     = inst_sram_rdata[15:0];
    assign imm_s   = {{16{imm[15]}}, imm};
    assign imm_z   = {16'h0, imm};
    assign pc4     = fetch_pc + 32'd4; // delay slot pc

    // youngest stage wins
    function automatic logic [`CPU_XLEN-1:0] fwd_val(input logic [`CPU_REG_AW-1:0] a,
                                                     input logic [`CPU_XLEN-1:0] rf);
        pipe_pkg::fwd_src_e sel;
        if (ex_we && ex_dest == a) sel = pipe_pkg::FWD_EX;
        else if (mem_we && mem_dest == a) sel = pipe_pkg::FWD_MEM;
        else if (wb_we && wb_dest == a) sel = pipe_pkg::FWD_WB;
        else sel = pipe_pkg::FWD_RF;
        case (sel)
            pipe_pkg::FWD_EX:  return ex_value;
            pipe_pkg::FWD_MEM: return mem_value;
            pipe_pkg::FWD_WB:  return wb_value;
            default:           return rf;
        endcase
    endfunction

    always_comb begin
        rs_val = fwd_val(rs_addr, rs_data);
        rt_val = fwd_val(rt_addr, rt_data);
    end

    always_comb begin
        alu_op = isa_pkg::ALU_ADD;
        src_a = rs_val;
        src_b = imm_s;
        mem_size = pipe_pkg::MEM_NONE;
        wb_src = pipe_pkg::WB_ALU;
        dest = rt_addr;
        {we, load_signed, store, uses_rs, uses_rt} = 5'b0;
        {is_shift, is_branch, is_jump, br_ne} = 4'b0;
        case (isa_pkg::opcode_e'(op))
            isa_pkg::OP_SPECIAL: begin
                dest = inst_sram_rdata[15:11];
                src_b = rt_val;
                {we, uses_rs, uses_rt} = 3'b111;
                case (isa_pkg::funct_e'(fn))
                    isa_pkg::F_SLL:  {alu_op, is_shift} = {isa_pkg::ALU_SLL, 1'b1};
                    isa_pkg::F_SRL:  {alu_op, is_shift} = {isa_pkg::ALU_SRL, 1'b1};
                    isa_pkg::F_SRA:  {alu_op, is_shift} = {isa_pkg::ALU_SRA, 1'b1};
                    isa_pkg::F_ADDU: alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::F_SUBU: alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::F_AND:  alu_op = isa_pkg::ALU_AND;
                    isa_pkg::F_OR:   alu_op = isa_pkg::ALU_OR;
                    isa_pkg::F_XOR:  alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::F_NOR:  alu_op = isa_pkg::ALU_NOR;
                    isa_pkg::F_SLT:  alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::F_SLTU: alu_op = isa_pkg::ALU_SLTU;
                    default:         we = 1'b0; // unknown funct is a no-op
                endcase
                if (is_shift) begin
                    src_a = rt_val; // shift amount rides in b
                    src_b = {27'h0, sa};
                    uses_rs = 1'b0;
                end
            end
            isa_pkg::OP_ADDIU: {we, uses_rs} = 2'b11;
            isa_pkg::OP_SLTI:  {alu_op, we, uses_rs} = {isa_pkg::ALU_SLT, 2'b11};
            isa_pkg::OP_SLTIU: {alu_op, we, uses_rs} = {isa_pkg::ALU_SLTU, 2'b11};
            isa_pkg::OP_ANDI:  {alu_op, src_b, we, uses_rs} = {isa_pkg::ALU_AND, imm_z, 2'b11};
            isa_pkg::OP_ORI:   {alu_op, src_b, we, uses_rs} = {isa_pkg::ALU_OR, imm_z, 2'b11};
            isa_pkg::OP_XORI:  {alu_op, src_b, we, uses_rs} = {isa_pkg::ALU_XOR, imm_z, 2'b11};
            isa_pkg::OP_LUI:   {alu_op, src_b, we} = {isa_pkg::ALU_LUI, imm_z, 1'b1};
            isa_pkg::OP_LB, isa_pkg::OP_LBU, isa_pkg::OP_LH, isa_pkg::OP_LHU,
            isa_pkg::OP_LW: begin
                {we, uses_rs} = 2'b11;
                wb_src = pipe_pkg::WB_MEM;
                load_signed = (op == isa_pkg::OP_LB) || (op == isa_pkg::OP_LH);
                if (op == isa_pkg::OP_LW) mem_size = pipe_pkg::MEM_WORD;
                else if (op[0]) mem_size = pipe_pkg::MEM_HALF;
                else mem_size = pipe_pkg::MEM_BYTE;
            end
            isa_pkg::OP_SB: {mem_size, store, uses_rs, uses_rt} = {pipe_pkg::MEM_BYTE, 3'b111};
            isa_pkg::OP_SH: {mem_size, store, uses_rs, uses_rt} = {pipe_pkg::MEM_HALF, 3'b111};
            isa_pkg::OP_SW: {mem_size, store, uses_rs, uses_rt} = {pipe_pkg::MEM_WORD, 3'b111};
            isa_pkg::OP_BEQ: {is_branch, uses_rs, uses_rt} = 3'b111;
            isa_pkg::OP_BNE: {is_branch, br_ne, uses_rs, uses_rt} = 4'b1111;
            isa_pkg::OP_J:   is_jump = 1'b1;
            isa_pkg::OP_JAL: begin
                {is_jump, we} = 2'b11;
                dest = `CPU_LINK_REG;
                wb_src = pipe_pkg::WB_LINK;
            end
            default: ; // unknown opcode runs as a no-op
        endcase
    end

    // load in execute feeding this word costs one cycle
    assign stall = dec_ok && ex_is_load &&
                   ((uses_rs && rs_addr == ex_dest) || (uses_rt && rt_addr == ex_dest));

    assign taken = is_jump || (is_branch && ((rs_val == rt_val) != br_ne));
    assign branch_taken = dec_ok && !stall && taken;
    assign branch_target = is_jump ? {pc4[31:28], inst_sram_rdata[25:0], 2'b00}
                                   : pc4 + {imm_s[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dec_ok <= 1'b0; // first fetch not back yet
            id_valid <= 1'b0;
        end else begin
            dec_ok <= 1'b1;
            id_valid <= dec_ok && !stall; // bubble on stall
        end
        id_pc          <= fetch_pc;
        id_alu_op      <= alu_op;
        id_src_a       <= src_a;
        id_src_b       <= src_b;
        id_store_data  <= rt_val;
        id_mem_size    <= mem_size;
        id_load_signed <= load_signed;
        id_store       <= store;
        id_wb_src      <= wb_src;
        id_dest        <= dest;
        id_we          <= we && dest != '0; // r0 writes dropped here
    end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 stall,
    input  logic                 branch_taken,
    input  logic [`CPU_XLEN-1:0] branch_target,
    output logic                 inst_sram_en,
    output logic [`CPU_XLEN-1:0] inst_sram_addr,
    output logic [`CPU_XLEN-1:0] fetch_pc
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] next_pc;

    assign inst_sram_en = 1'b1; // fetches every cycle

    // a stalled decode word is read again so it is still there next cycle
    assign inst_sram_addr = stall ? fetch_pc : pc;

    always_comb begin
        if (stall) begin
            next_pc = pc;
        end else if (branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= `CPU_RESET_PC;
        end else begin
            pc <= next_pc;
        end
        if (!stall) begin
            fetch_pc <= pc; // pc of the word returning next cycle
        end
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
    input  logic                   clk,
    input  logic [`CPU_REG_AW-1:0] rs_addr,
    input  logic [`CPU_REG_AW-1:0] rt_addr,
    output logic [`CPU_XLEN-1:0]   rs_data,
    output logic [`CPU_XLEN-1:0]   rt_data,
    input  logic                   we,
    input  logic [`CPU_REG_AW-1:0] wa,
    input  logic [`CPU_XLEN-1:0]   wd
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_NUM];

    // r0 reads as zero whatever the array holds
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

endmodule

//--- pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_e;

    // where the register write value comes from
    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_LINK
    } wb_src_e;

    // operand source seen by decode
    typedef enum logic [1:0] {
        FWD_RF, FWD_EX, FWD_MEM, FWD_WB
    } fwd_src_e;

endpackage

//--- isa_pkg.sv
package isa_pkg;

    // primary opcodes, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } opcode_e;

    // function codes of the SPECIAL group
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

endpackage

//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and address width
`define CPU_XLEN 32

// register file geometry
`define CPU_REG_AW  5
`define CPU_REG_NUM 32

`define CPU_RESET_PC 32'h0000_0000
`define CPU_LINK_REG 5'd31 // jal destination

`endif
